// ==== axi_bridge_params.svh ====
`ifndef AXI_BRIDGE_PARAMS_SVH
`define AXI_BRIDGE_PARAMS_SVH

// byte address on the AXI side
`define AXI_ADDR_W 32

// one R or W beat
`define AXI_DATA_W 32

// words per cache line
`define LINE_WORDS 8

// full line, word 0 in the low bits
`define LINE_W (`LINE_WORDS * `AXI_DATA_W)

// AXI length field of a line burst
`define LINE_LEN (`LINE_WORDS - 1)

`endif

// ==== axi_bridge_pkg.sv ====
`default_nettype none

`include "axi_bridge_params.svh"

package axi_bridge_pkg;

    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_DATA_W-1:0] word_t;
    typedef logic [`AXI_DATA_W/8-1:0] strb_t; // one bit per byte lane
    typedef logic [`LINE_W-1:0] line_t;
    typedef logic [3:0] axlen_t; // AXI3 length, beats minus one
    typedef logic [2:0] axsize_t; // log2 of bytes per beat

    // sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR,
        ST_RD,
        ST_REFRESH,
        ST_COOL
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== bridge_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_bridge_params.svh"

module bridge_ctrl (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        dcache_ren,
    input  wire axi_bridge_pkg::addr_t dcache_raddr,
    input  wire                        dcache_wen,
    input  wire axi_bridge_pkg::addr_t dcache_waddr,
    input  wire axi_bridge_pkg::line_t dcache_line_old,
    input  wire                        uncache_en,
    input  wire axi_bridge_pkg::strb_t uncache_wen,
    input  wire axi_bridge_pkg::addr_t uncache_addr,
    input  wire axi_bridge_pkg::word_t uncache_wdata,
    input  wire                        wr_done,
    input  wire                        rd_done,
    input  wire axi_bridge_pkg::line_t rd_line,
    output axi_bridge_pkg::line_t      dcache_line_new,
    output logic                       dcache_refresh,
    output axi_bridge_pkg::word_t      uncache_rdata,
    output logic                       uncache_refresh,
    output logic                       wr_start,
    output axi_bridge_pkg::addr_t      wr_addr,
    output axi_bridge_pkg::axlen_t     wr_len,
    output axi_bridge_pkg::strb_t      wr_strb,
    output axi_bridge_pkg::line_t      wr_line,
    output logic                       rd_start,
    output axi_bridge_pkg::addr_t      rd_addr,
    output axi_bridge_pkg::axlen_t     rd_len
);

    axi_bridge_pkg::ctrl_state_t state;
    logic sel_dc; // data cache owns this transaction
    logic rd_pend; // read phase follows the write
    logic dc_req;
    logic unc_wr;

    assign dc_req = dcache_wen | dcache_ren;
    assign unc_wr = |uncache_wen;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state           <= axi_bridge_pkg::ST_IDLE;
            sel_dc          <= 1'b0;
            rd_pend         <= 1'b0;
            wr_start        <= 1'b0;
            rd_start        <= 1'b0;
            dcache_refresh  <= 1'b0;
            uncache_refresh <= 1'b0;
        end else begin
            wr_start <= 1'b0;
            rd_start <= 1'b0;
            case (state)
                axi_bridge_pkg::ST_IDLE: begin
                    if (dc_req) begin // data cache has priority
                        sel_dc   <= 1'b1;
                        rd_pend  <= dcache_ren;
                        wr_start <= dcache_wen;
                        rd_start <= ~dcache_wen;
                        state    <= dcache_wen ? axi_bridge_pkg::ST_WR : axi_bridge_pkg::ST_RD;
                    end else if (uncache_en) begin
                        sel_dc   <= 1'b0;
                        rd_pend  <= ~unc_wr;
                        wr_start <= unc_wr;
                        rd_start <= ~unc_wr;
                        state    <= unc_wr ? axi_bridge_pkg::ST_WR : axi_bridge_pkg::ST_RD;
                    end
                end
                axi_bridge_pkg::ST_WR: begin
                    if (wr_done) begin
                        if (rd_pend) begin // writeback done, now the refill
                            rd_start <= 1'b1;
                            state    <= axi_bridge_pkg::ST_RD;
                        end else begin
                            dcache_refresh  <= sel_dc;
                            uncache_refresh <= ~sel_dc;
                            state           <= axi_bridge_pkg::ST_REFRESH;
                        end
                    end
                end
                axi_bridge_pkg::ST_RD: begin
                    if (rd_done) begin
                        dcache_refresh  <= sel_dc;
                        uncache_refresh <= ~sel_dc;
                        state           <= axi_bridge_pkg::ST_REFRESH;
                    end
                end
                axi_bridge_pkg::ST_REFRESH: begin
                    dcache_refresh  <= 1'b0;
                    uncache_refresh <= 1'b0;
                    state           <= axi_bridge_pkg::ST_COOL;
                end
                axi_bridge_pkg::ST_COOL: begin
                    state <= axi_bridge_pkg::ST_IDLE; // client drops its request here
                end
                default: begin
                    state <= axi_bridge_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == axi_bridge_pkg::ST_IDLE) begin
            if (dc_req) begin
                wr_addr <= dcache_waddr;
                wr_len  <= axi_bridge_pkg::axlen_t'(`LINE_LEN);
                wr_strb <= '1;
                wr_line <= dcache_line_old;
                rd_addr <= dcache_raddr;
                rd_len  <= axi_bridge_pkg::axlen_t'(`LINE_LEN);
            end else begin
                wr_addr <= uncache_addr;
                wr_len  <= '0;
                wr_strb <= uncache_wen;
                wr_line <= {{(`LINE_W - `AXI_DATA_W){1'b0}}, uncache_wdata}; // word 0 only
                rd_addr <= uncache_addr;
                rd_len  <= '0;
            end
        end
        if (rd_done) begin
            if (sel_dc) begin
                dcache_line_new <= rd_line;
            end else begin
                uncache_rdata <= rd_line[`AXI_DATA_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== axi_read_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_bridge_params.svh"

module axi_read_engine (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         rd_start,
    input  wire axi_bridge_pkg::addr_t  rd_addr,
    input  wire axi_bridge_pkg::axlen_t rd_len,
    input  wire                         arready,
    input  wire axi_bridge_pkg::word_t  rdata,
    input  wire                         rlast,
    input  wire                         rvalid,
    output logic                        rd_done,
    output axi_bridge_pkg::line_t       rd_line,
    output axi_bridge_pkg::addr_t       araddr,
    output axi_bridge_pkg::axlen_t      arlen,
    output logic                        arvalid,
    output logic                        rready
);

    localparam int IDX_W = $clog2(`LINE_WORDS);

    logic [IDX_W-1:0] beat; // word slot of the next R beat
    logic r_hs;

    assign r_hs = rready & rvalid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            arvalid <= 1'b0;
            rready  <= 1'b0;
            rd_done <= 1'b0;
            beat    <= '0;
        end else begin
            rd_done <= 1'b0;
            if (rd_start) begin
                arvalid <= 1'b1;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1; // open R once AR is taken
                beat    <= '0;
            end
            if (r_hs) begin
                beat <= beat + 1'b1;
                if (rlast) begin
                    rready  <= 1'b0;
                    rd_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            araddr <= rd_addr;
            arlen  <= rd_len;
        end
        if (r_hs) begin
            rd_line[beat*`AXI_DATA_W +: `AXI_DATA_W] <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== axi_write_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axi_bridge_params.svh"

module axi_write_engine (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         wr_start,
    input  wire axi_bridge_pkg::addr_t  wr_addr,
    input  wire axi_bridge_pkg::axlen_t wr_len,
    input  wire axi_bridge_pkg::strb_t  wr_strb,
    input  wire axi_bridge_pkg::line_t  wr_line,
    input  wire                         awready,
    input  wire                         wready,
    input  wire                         bvalid,
    output logic                        wr_done,
    output axi_bridge_pkg::addr_t       awaddr,
    output axi_bridge_pkg::axlen_t      awlen,
    output axi_bridge_pkg::axsize_t     awsize,
    output logic                        awvalid,
    output axi_bridge_pkg::word_t       wdata,
    output axi_bridge_pkg::strb_t       wstrb,
    output logic                        wlast,
    output logic                        wvalid,
    output logic                        bready
);

    localparam int IDX_W = $clog2(`LINE_WORDS);

    axi_bridge_pkg::axlen_t beat; // beat being loaded into wdata
    logic aw_hs;
    logic w_hs;

    // narrowest size that covers the strobe pattern
    function automatic axi_bridge_pkg::axsize_t size_of(input axi_bridge_pkg::strb_t s);
        case (s)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: size_of = 3'd0;
            4'b0011, 4'b1100:                   size_of = 3'd1;
            default:                            size_of = 3'd2;
        endcase
    endfunction

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            wlast   <= 1'b0;
            bready  <= 1'b0;
            wr_done <= 1'b0;
            beat    <= '0;
        end else begin
            wr_done <= 1'b0;
            if (wr_start) begin
                awvalid <= 1'b1;
                bready  <= 1'b1; // raised with awvalid
            end else if (aw_hs) begin
                awvalid <= 1'b0;
                wvalid  <= 1'b1;
                wlast   <= (awlen == '0);
                beat    <= axi_bridge_pkg::axlen_t'(1);
            end else if (w_hs) begin
                if (wlast) begin
                    wvalid <= 1'b0;
                    wlast  <= 1'b0;
                end else begin
                    wlast <= (beat == awlen);
                    beat  <= beat + 1'b1;
                end
            end
            if (bready && bvalid) begin
                bready  <= 1'b0;
                wr_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start) begin
            awaddr <= wr_addr;
            awlen  <= wr_len;
            awsize <= size_of(wr_strb);
            wstrb  <= wr_strb;
        end
        if (aw_hs) begin
            wdata <= wr_line[`AXI_DATA_W-1:0];
        end else if (w_hs && !wlast) begin
            wdata <= wr_line[beat[IDX_W-1:0]*`AXI_DATA_W +: `AXI_DATA_W]; // next word
        end
    end

endmodule

`default_nettype wire

// ==== axi_bridge_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_bridge_top (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          dcache_ren,
    input  wire axi_bridge_pkg::addr_t   dcache_raddr,
    input  wire                          dcache_wen,
    input  wire axi_bridge_pkg::addr_t   dcache_waddr,
    input  wire axi_bridge_pkg::line_t   dcache_line_old,
    output wire axi_bridge_pkg::line_t   dcache_line_new,
    output wire                          dcache_refresh,
    input  wire                          uncache_en,
    input  wire axi_bridge_pkg::strb_t   uncache_wen,
    input  wire axi_bridge_pkg::addr_t   uncache_addr,
    input  wire axi_bridge_pkg::word_t   uncache_wdata,
    output wire axi_bridge_pkg::word_t   uncache_rdata,
    output wire                          uncache_refresh,
    output wire axi_bridge_pkg::addr_t   araddr,
    output wire axi_bridge_pkg::axlen_t  arlen,
    output wire                          arvalid,
    input  wire                          arready,
    input  wire axi_bridge_pkg::word_t   rdata,
    input  wire                          rlast,
    input  wire                          rvalid,
    output wire                          rready,
    output wire axi_bridge_pkg::addr_t   awaddr,
    output wire axi_bridge_pkg::axlen_t  awlen,
    output wire axi_bridge_pkg::axsize_t awsize,
    output wire                          awvalid,
    input  wire                          awready,
    output wire axi_bridge_pkg::word_t   wdata,
    output wire axi_bridge_pkg::strb_t   wstrb,
    output wire                          wlast,
    output wire                          wvalid,
    input  wire                          wready,
    input  wire                          bvalid,
    output wire                          bready
);

    wire                         wr_start;
    wire axi_bridge_pkg::addr_t  wr_addr;
    wire axi_bridge_pkg::axlen_t wr_len;
    wire axi_bridge_pkg::strb_t  wr_strb;
    wire axi_bridge_pkg::line_t  wr_line;
    wire                         wr_done;
    wire                         rd_start;
    wire axi_bridge_pkg::addr_t  rd_addr;
    wire axi_bridge_pkg::axlen_t rd_len;
    wire                         rd_done;
    wire axi_bridge_pkg::line_t  rd_line;

    bridge_ctrl u_ctrl (
        .clk(clk), .rstn(rstn),
        .dcache_ren(dcache_ren), .dcache_raddr(dcache_raddr),
        .dcache_wen(dcache_wen), .dcache_waddr(dcache_waddr),
        .dcache_line_old(dcache_line_old),
        .uncache_en(uncache_en), .uncache_wen(uncache_wen),
        .uncache_addr(uncache_addr), .uncache_wdata(uncache_wdata),
        .wr_done(wr_done), .rd_done(rd_done), .rd_line(rd_line),
        .dcache_line_new(dcache_line_new), .dcache_refresh(dcache_refresh),
        .uncache_rdata(uncache_rdata), .uncache_refresh(uncache_refresh),
        .wr_start(wr_start), .wr_addr(wr_addr), .wr_len(wr_len),
        .wr_strb(wr_strb), .wr_line(wr_line),
        .rd_start(rd_start), .rd_addr(rd_addr), .rd_len(rd_len)
    );

    axi_read_engine u_rd (
        .clk(clk), .rstn(rstn),
        .rd_start(rd_start), .rd_addr(rd_addr), .rd_len(rd_len),
        .arready(arready), .rdata(rdata), .rlast(rlast), .rvalid(rvalid),
        .rd_done(rd_done), .rd_line(rd_line),
        .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .rready(rready)
    );

    axi_write_engine u_wr (
        .clk(clk), .rstn(rstn),
        .wr_start(wr_start), .wr_addr(wr_addr), .wr_len(wr_len),
        .wr_strb(wr_strb), .wr_line(wr_line),
        .awready(awready), .wready(wready), .bvalid(bvalid),
        .wr_done(wr_done),
        .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awvalid(awvalid),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid),
        .bready(bready)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_axi_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem_model (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          stall_en,
    input  wire axi_bridge_pkg::addr_t   araddr,
    input  wire axi_bridge_pkg::axlen_t  arlen,
    input  wire                          arvalid,
    output logic                         arready,
    output axi_bridge_pkg::word_t        rdata,
    output logic                         rlast,
    output logic                         rvalid,
    input  wire                          rready,
    input  wire axi_bridge_pkg::addr_t   awaddr,
    input  wire axi_bridge_pkg::axlen_t  awlen,
    input  wire axi_bridge_pkg::axsize_t awsize,
    input  wire                          awvalid,
    output logic                         awready,
    input  wire axi_bridge_pkg::word_t   wdata,
    input  wire axi_bridge_pkg::strb_t   wstrb,
    input  wire                          wlast,
    input  wire                          wvalid,
    output logic                         wready,
    output logic                         bvalid,
    input  wire                          bready
);

    axi_bridge_pkg::word_t words [0:255]; // word index is addr[9:2]

    // last requests seen on the bus
    axi_bridge_pkg::addr_t   ar_addr_seen;
    axi_bridge_pkg::axlen_t  ar_len_seen;
    axi_bridge_pkg::axlen_t  aw_len_seen;
    axi_bridge_pkg::axsize_t aw_size_seen;
    axi_bridge_pkg::strb_t   w_strb_seen;
    time                     ar_time;
    time                     aw_time;

    logic [7:0]             rd_ptr;
    logic [7:0]             wr_ptr;
    axi_bridge_pkg::axlen_t rd_left;
    logic                   rd_busy;
    logic                   wr_busy;
    logic                   b_pend;
    logic                   r_hold; // beat offered but not yet taken
    logic                   b_hold;

    function automatic logic go(input logic en);
        go = en ? (($urandom % 4) != 0) : 1'b1; // stall one cycle in four
    endfunction

    initial begin
        arready = 1'b0;
        rdata   = '0;
        rlast   = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
    end

    always @(posedge clk) begin
        r_hold = rvalid && !rready;
        b_hold = bvalid && !bready;
        if (!rstn) begin
            rd_busy = 1'b0;
            wr_busy = 1'b0;
            b_pend  = 1'b0;
            rd_ptr  = '0;
            rd_left = '0;
            #1;
            arready = 1'b0;
            rvalid  = 1'b0;
            rlast   = 1'b0;
            awready = 1'b0;
            wready  = 1'b0;
            bvalid  = 1'b0;
        end else begin
            if (arvalid && arready) begin
                rd_ptr       = araddr[9:2];
                rd_left      = arlen;
                rd_busy      = 1'b1;
                ar_addr_seen = araddr;
                ar_len_seen  = arlen;
                ar_time      = $time;
            end
            if (rvalid && rready) begin
                if (rlast) begin
                    rd_busy = 1'b0;
                end else begin
                    rd_ptr  = rd_ptr + 1'b1;
                    rd_left = rd_left - 1'b1;
                end
            end
            if (awvalid && awready) begin
                wr_ptr       = awaddr[9:2];
                wr_busy      = 1'b1;
                aw_len_seen  = awlen;
                aw_size_seen = awsize;
                aw_time      = $time;
            end
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        words[wr_ptr][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
                w_strb_seen = wstrb;
                wr_ptr      = wr_ptr + 1'b1;
                if (wlast) begin
                    wr_busy = 1'b0;
                    b_pend  = 1'b1;
                end
            end
            if (bvalid && bready) begin
                b_pend = 1'b0;
            end
            #1;
            arready = !rd_busy && go(stall_en);
            if (!r_hold) begin
                rvalid = rd_busy && go(stall_en);
                rdata  = words[rd_ptr];
                rlast  = (rd_left == 0);
            end
            awready = !wr_busy && !b_pend && go(stall_en);
            wready  = wr_busy && go(stall_en);
            if (!b_hold) begin
                bvalid = b_pend && go(stall_en);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_axi_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axi_bridge;

    wire                            clk;
    wire                            rstn;
    logic                           stall_en;
    logic                           dcache_ren;
    axi_bridge_pkg::addr_t          dcache_raddr;
    logic                           dcache_wen;
    axi_bridge_pkg::addr_t          dcache_waddr;
    axi_bridge_pkg::line_t          dcache_line_old;
    wire axi_bridge_pkg::line_t     dcache_line_new;
    wire                            dcache_refresh;
    logic                           uncache_en;
    axi_bridge_pkg::strb_t          uncache_wen;
    axi_bridge_pkg::addr_t          uncache_addr;
    axi_bridge_pkg::word_t          uncache_wdata;
    wire axi_bridge_pkg::word_t     uncache_rdata;
    wire                            uncache_refresh;
    wire axi_bridge_pkg::addr_t     araddr;
    wire axi_bridge_pkg::axlen_t    arlen;
    wire                            arvalid;
    wire                            arready;
    wire axi_bridge_pkg::word_t     rdata;
    wire                            rlast;
    wire                            rvalid;
    wire                            rready;
    wire axi_bridge_pkg::addr_t     awaddr;
    wire axi_bridge_pkg::axlen_t    awlen;
    wire axi_bridge_pkg::axsize_t   awsize;
    wire                            awvalid;
    wire                            awready;
    wire axi_bridge_pkg::word_t     wdata;
    wire axi_bridge_pkg::strb_t     wstrb;
    wire                            wlast;
    wire                            wvalid;
    wire                            wready;
    wire                            bvalid;
    wire                            bready;

    axi_bridge_pkg::word_t mirror [0:255]; // expected memory contents
    int errors = 0;
    int checks = 0;
    int dc_ref_cnt = 0;
    int unc_ref_cnt = 0;

    tb_clock_gen u_clk (.clk(clk), .rstn(rstn));
    tb_axi_mem_model u_mem (.*);
    axi_bridge_top uut (.*);

    always @(posedge clk) begin
        if (dcache_refresh) dc_ref_cnt++;
        if (uncache_refresh) unc_ref_cnt++;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_fail(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    task automatic wait_refresh(input logic dc, output logic ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < 400) begin
            @(posedge clk);
            ok = dc ? dcache_refresh : uncache_refresh;
            n++;
        end
        #1;
        if (!ok && dc) report_fail("timeout waiting for dcache_refresh");
        if (!ok && !dc) report_fail("timeout waiting for uncache_refresh");
    endtask

    task automatic settle();
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic clear_counts();
        dc_ref_cnt         = 0;
        unc_ref_cnt        = 0;
        u_mem.ar_time      = 0;
        u_mem.aw_time      = 0;
        u_mem.ar_addr_seen = 'x;
        u_mem.aw_size_seen = 'x;
        u_mem.w_strb_seen  = 'x;
    endtask

    task automatic mirror_write(input axi_bridge_pkg::addr_t addr,
                                input axi_bridge_pkg::word_t data,
                                input axi_bridge_pkg::strb_t strb);
        int b;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) mirror[addr[9:2]][8*b +: 8] = data[8*b +: 8];
        end
    endtask

    function automatic axi_bridge_pkg::line_t random_line();
        axi_bridge_pkg::line_t l;
        int k;
        for (k = 0; k < 8; k++) l[32*k +: 32] = $urandom;
        return l;
    endfunction

    task automatic check_line(input axi_bridge_pkg::addr_t addr);
        int k;
        for (k = 0; k < 8; k++) begin
            check_val($sformatf("dcache_line_new[%0d]", k), dcache_line_new[32*k +: 32],
                      mirror[addr[9:2] + k]);
        end
        check_val("araddr", u_mem.ar_addr_seen, addr);
        check_val("arlen", u_mem.ar_len_seen, 32'd7);
    endtask

    task automatic reset_state();
        int n;
        for (n = 0; n < 20 && rstn !== 1'b1; n++) @(posedge clk);
        if (rstn !== 1'b1) report_fail("reset was never released");
        @(posedge clk);
        #1;
        check_val("arvalid", arvalid, 0);
        check_val("awvalid", awvalid, 0);
        check_val("wvalid", wvalid, 0);
        check_val("wlast", wlast, 0);
        check_val("rready", rready, 0);
        check_val("bready", bready, 0);
        check_val("dcache_refresh", dcache_refresh, 0);
        check_val("uncache_refresh", uncache_refresh, 0);
    endtask

    task automatic line_refill(input axi_bridge_pkg::addr_t addr);
        logic ok;
        clear_counts();
        dcache_ren   = 1'b1;
        dcache_raddr = addr;
        wait_refresh(1'b1, ok);
        dcache_ren = 1'b0;
        if (ok) check_line(addr);
        settle();
        check_val("dcache_refresh pulses", dc_ref_cnt, 1);
    endtask

    task automatic writeback_refill(input axi_bridge_pkg::addr_t waddr,
                                    input axi_bridge_pkg::addr_t raddr);
        axi_bridge_pkg::line_t line;
        logic ok;
        int k;
        line = random_line();
        for (k = 0; k < 8; k++) mirror_write(waddr + 4*k, line[32*k +: 32], 4'hf);
        clear_counts();
        dcache_wen      = 1'b1;
        dcache_ren      = 1'b1;
        dcache_waddr    = waddr;
        dcache_raddr    = raddr;
        dcache_line_old = line;
        wait_refresh(1'b1, ok);
        dcache_wen = 1'b0;
        dcache_ren = 1'b0;
        if (ok) begin
            if (!(u_mem.aw_time > 0 && u_mem.ar_time > u_mem.aw_time))
                report_fail("AW request did not come before the AR request");
            for (k = 0; k < 8; k++) begin
                check_val($sformatf("mem[%0d]", waddr[9:2] + k), u_mem.words[waddr[9:2] + k],
                          line[32*k +: 32]);
            end
            check_val("awlen", u_mem.aw_len_seen, 32'd7);
            check_line(raddr);
        end
        settle();
        check_val("dcache_refresh pulses", dc_ref_cnt, 1);
    endtask

    task automatic uncached_write(input axi_bridge_pkg::addr_t addr,
                                  input axi_bridge_pkg::strb_t strb,
                                  input axi_bridge_pkg::axsize_t exp_size);
        axi_bridge_pkg::word_t data;
        logic ok;
        data = $urandom;
        mirror_write(addr, data, strb);
        clear_counts();
        uncache_en    = 1'b1;
        uncache_wen   = strb;
        uncache_addr  = addr;
        uncache_wdata = data;
        wait_refresh(1'b0, ok);
        uncache_en  = 1'b0;
        uncache_wen = '0;
        if (ok) begin
            check_val("awsize", u_mem.aw_size_seen, exp_size);
            check_val("wstrb", u_mem.w_strb_seen, strb);
            check_val("awlen", u_mem.aw_len_seen, 0);
            check_val("mem word", u_mem.words[addr[9:2]], mirror[addr[9:2]]);
        end
        settle();
        check_val("uncache_refresh pulses", unc_ref_cnt, 1);
    endtask

    task automatic uncached_read(input axi_bridge_pkg::addr_t addr);
        logic ok;
        clear_counts();
        uncache_en   = 1'b1;
        uncache_wen  = '0;
        uncache_addr = addr;
        wait_refresh(1'b0, ok);
        uncache_en = 1'b0;
        if (ok) begin
            check_val("uncache_rdata", uncache_rdata, mirror[addr[9:2]]);
            check_val("arlen", u_mem.ar_len_seen, 0);
        end
        settle();
        check_val("uncache_refresh pulses", unc_ref_cnt, 1);
    endtask

    task automatic run_suite(input axi_bridge_pkg::addr_t base);
        line_refill(base);
        writeback_refill(base + 'h20, base + 'h20); // refill sees the new line
        writeback_refill(base + 'h40, base + 'h60);
        uncached_write(base + 'h84, 4'b0001, 3'd0);
        uncached_write(base + 'h84, 4'b0100, 3'd0);
        uncached_write(base + 'h84, 4'b0011, 3'd1);
        uncached_write(base + 'h88, 4'b1100, 3'd1);
        uncached_write(base + 'h8c, 4'b1111, 3'd2);
        uncached_read(base + 'h84);
        uncached_read(base + 'h88);
    endtask

    task automatic priority_check(input axi_bridge_pkg::addr_t line_addr,
                                  input axi_bridge_pkg::addr_t word_addr);
        logic ok;
        clear_counts();
        dcache_ren   = 1'b1;
        dcache_raddr = line_addr;
        uncache_en   = 1'b1;
        uncache_wen  = '0;
        uncache_addr = word_addr;
        wait_refresh(1'b1, ok);
        dcache_ren = 1'b0; // uncached client keeps waiting
        if (unc_ref_cnt != 0) report_fail("uncached read finished before the line refill");
        if (ok) check_line(line_addr);
        wait_refresh(1'b0, ok);
        uncache_en = 1'b0;
        if (ok) check_val("uncache_rdata", uncache_rdata, mirror[word_addr[9:2]]);
        settle();
        check_val("dcache_refresh pulses", dc_ref_cnt, 1);
        check_val("uncache_refresh pulses", unc_ref_cnt, 1);
    endtask

    initial begin
        void'($urandom(32'hbf9a_5a4c));
        stall_en        = 1'b0;
        dcache_ren      = 1'b0;
        dcache_raddr    = '0;
        dcache_wen      = 1'b0;
        dcache_waddr    = '0;
        dcache_line_old = '0;
        uncache_en      = 1'b0;
        uncache_wen     = '0;
        uncache_addr    = '0;
        uncache_wdata   = '0;
        for (int i = 0; i < 256; i++) begin
            mirror[i]       = $urandom;
            u_mem.words[i] = mirror[i];
        end
        reset_state();
        run_suite(32'h0000_0000);
        stall_en = 1'b1; // slave now stalls at random
        run_suite(32'h0000_0100);
        priority_check(32'h0000_0200, 32'h0000_0244);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
axi_bridge_pkg.sv
bridge_ctrl.sv
axi_read_engine.sv
axi_write_engine.sv
axi_bridge_top.sv
tb_clock_gen.sv
tb_axi_mem_model.sv
tb_axi_bridge.sv
